//--- source/joiner_params.svh
`ifndef JOINER_PARAMS_SVH
`define JOINER_PARAMS_SVH

// Number of input stream channels
`define JOIN_CHANNELS 3

// Stream data width in bits
`define JOIN_DATA_WIDTH 16

// One keep bit per data byte
`define JOIN_KEEP_WIDTH 2

// Width of an encoded channel index
`define JOIN_SEL_WIDTH(n) (((n) > 1) ? $clog2(n) : 1)

`endif

//--- source/join_ctrl_pkg.sv
package join_ctrl_pkg;

  // Join controller states
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_oper  = 2'd1,
    st_error = 2'd2,
    st_end   = 2'd3
  } join_state_e;

endpackage

//--- source/arb_pkg.sv
package arb_pkg;

  // Arbiter states
  typedef enum logic {
    arb_idle = 1'b0,
    // Grant stays fixed for a whole packet
    arb_hold = 1'b1
  } arb_state_e;

endpackage

//--- source/packet_arbiter.sv
`timescale 1ns/10ps
`include "joiner_params.svh"

module packet_arbiter #(
  parameter int CHANNELS = `JOIN_CHANNELS,
  localparam int IDX_W = `JOIN_SEL_WIDTH(CHANNELS)
) (
  input  logic                clk,
  input  logic                int_rst,
  input  logic                restart,
  input  logic [CHANNELS-1:0] request,
  input  logic [CHANNELS-1:0] acknowledge,
  output logic [CHANNELS-1:0] grant,
  output logic                grant_valid,
  output logic [IDX_W-1:0]    grant_index
);

  arb_pkg::arb_state_e state;

  // Channel where the next search begins
  logic [IDX_W-1:0]    search_base;

  logic                pick_found;
  logic [IDX_W-1:0]    pick_index;
  logic [CHANNELS-1:0] pick_onehot;
  logic [IDX_W-1:0]    next_base;

  // Round-robin search, wrapping past the top channel
  always_comb begin
    int idx;
    pick_found = 1'b0;
    pick_index = '0;
    for (int i = 0; i < CHANNELS; i++) begin
      idx = (int'(search_base) + i) % CHANNELS;
      if (!pick_found && request[idx]) begin
        pick_found = 1'b1;
        pick_index = IDX_W'(idx);
      end
    end
  end

  assign pick_onehot = CHANNELS'(1) << pick_index;
  assign next_base   = (int'(pick_index) == CHANNELS - 1) ? '0 : pick_index + 1'b1;
  assign grant_valid = (state == arb_pkg::arb_hold);

  always_ff @(posedge clk) begin
    if (int_rst || restart) begin
      state       <= arb_pkg::arb_idle;
      grant       <= '0;
      grant_index <= '0;
      search_base <= '0;
    end else begin
      case (state)
        arb_pkg::arb_idle: begin
          if (pick_found) begin
            state       <= arb_pkg::arb_hold;
            grant       <= pick_onehot;
            grant_index <= pick_index;
            search_base <= next_base;
          end
        end
        arb_pkg::arb_hold: begin
          // Release once the granted packet has ended
          if (|(acknowledge & grant)) begin
            state <= arb_pkg::arb_idle;
            grant <= '0;
          end
        end
        default: begin
          state <= arb_pkg::arb_idle;
          grant <= '0;
        end
      endcase
    end
  end

  grant_onehot_a: assert property (@(posedge clk) disable iff (int_rst)
    $onehot0(grant) && ((grant != '0) == grant_valid));

endmodule

//--- source/stream_mux.sv
`timescale 1ns/10ps
`include "joiner_params.svh"

module stream_mux #(
  parameter int CHANNELS   = `JOIN_CHANNELS,
  parameter int DATA_WIDTH = `JOIN_DATA_WIDTH,
  parameter int KEEP_WIDTH = `JOIN_KEEP_WIDTH,
  localparam int SEL_W     = `JOIN_SEL_WIDTH(CHANNELS)
) (
  input  logic [CHANNELS*DATA_WIDTH-1:0] s_tdata,
  input  logic [CHANNELS*KEEP_WIDTH-1:0] s_tkeep,
  input  logic [CHANNELS-1:0]            s_tvalid,
  input  logic [CHANNELS-1:0]            s_tlast,
  output logic [CHANNELS-1:0]            s_tready,
  input  logic                           enable,
  input  logic [SEL_W-1:0]               select,
  output logic [DATA_WIDTH-1:0]          m_tdata,
  output logic [KEEP_WIDTH-1:0]          m_tkeep,
  output logic                           m_tvalid,
  output logic                           m_tlast,
  input  logic                           m_tready
);

  logic sel_ok;

  // Guard against an index past the last channel
  assign sel_ok = enable && (int'(select) < CHANNELS);

  always_comb begin
    m_tdata  = '0;
    m_tkeep  = '0;
    m_tvalid = 1'b0;
    m_tlast  = 1'b0;
    s_tready = '0;

    if (sel_ok) begin
      m_tdata  = s_tdata[select*DATA_WIDTH +: DATA_WIDTH];
      m_tkeep  = s_tkeep[select*KEEP_WIDTH +: KEEP_WIDTH];
      m_tvalid = s_tvalid[select];
      m_tlast  = s_tlast[select];
      // Back-pressure reaches the selected source only
      s_tready[select] = m_tready;
    end

    valid_needs_enable_a: assert (!m_tvalid || enable);
  end

endmodule

//--- source/packet_joiner.sv
`timescale 1ns/10ps
`include "joiner_params.svh"

module packet_joiner (
  input  logic                                        clk,
  input  logic                                        int_rst,
  input  logic                                        abort,
  input  logic                                        op_start,
  input  logic [`JOIN_CHANNELS-1:0]                   use_channels,
  input  logic [`JOIN_CHANNELS*`JOIN_DATA_WIDTH-1:0]  s_tdata,
  input  logic [`JOIN_CHANNELS*`JOIN_KEEP_WIDTH-1:0]  s_tkeep,
  input  logic [`JOIN_CHANNELS-1:0]                   s_tvalid,
  input  logic [`JOIN_CHANNELS-1:0]                   s_tlast,
  output logic [`JOIN_CHANNELS-1:0]                   s_tready,
  output logic [`JOIN_DATA_WIDTH-1:0]                 m_tdata,
  output logic [`JOIN_KEEP_WIDTH-1:0]                 m_tkeep,
  output logic                                        m_tvalid,
  output logic                                        m_tlast,
  input  logic                                        m_tready,
  output logic                                        op_busy,
  output logic                                        op_complete,
  output logic                                        op_error,
  output logic                                        beat_xfer
);

  localparam int CHANNELS = `JOIN_CHANNELS;
  localparam int SEL_W    = `JOIN_SEL_WIDTH(`JOIN_CHANNELS);

  join_ctrl_pkg::join_state_e state, state_next;

  // Channels still waiting to be sent
  logic [CHANNELS-1:0] mask_reg;

  logic [CHANNELS-1:0] grant;
  logic                grant_valid;
  logic [SEL_W-1:0]    grant_index;

  logic [CHANNELS-1:0] s_tvalid_gated;
  logic [CHANNELS-1:0] acknowledge;
  logic                mux_tlast;
  logic                last_packet;
  logic                final_xfer;
  logic                start_ok;

  assign s_tvalid_gated = s_tvalid & mask_reg;
  assign acknowledge    = s_tlast & s_tvalid_gated & s_tready & grant;

  // Nothing left in the mask besides the channel on the bus
  assign last_packet = ((mask_reg & ~grant) == '0);
  assign m_tlast     = mux_tlast && last_packet;
  assign final_xfer  = m_tvalid && m_tready && m_tlast;

  assign start_ok = op_start && (state == join_ctrl_pkg::st_idle ||
                                 state == join_ctrl_pkg::st_end);

  always_comb begin
    state_next = state;
    case (state)
      join_ctrl_pkg::st_idle, join_ctrl_pkg::st_end: begin
        state_next = join_ctrl_pkg::st_idle;
        if (op_start) begin
          state_next = (use_channels != '0) ? join_ctrl_pkg::st_oper : join_ctrl_pkg::st_error;
        end
      end
      join_ctrl_pkg::st_oper: begin
        if (final_xfer) begin
          state_next = join_ctrl_pkg::st_end;
        end
      end
      default: begin
        state_next = join_ctrl_pkg::st_idle;
      end
    endcase
    // Abort wins over everything
    if (abort) begin
      state_next = join_ctrl_pkg::st_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (int_rst) begin
      state     <= join_ctrl_pkg::st_idle;
      mask_reg  <= '0;
      beat_xfer <= 1'b0;
    end else begin
      state     <= state_next;
      beat_xfer <= m_tvalid && m_tready;
      if (abort) begin
        mask_reg <= '0;
      end else if (start_ok) begin
        mask_reg <= use_channels;
      end else begin
        // Drop each channel once its packet is done
        mask_reg <= mask_reg & ~acknowledge;
      end
    end
  end

  // Status decoded from the registered state
  assign op_busy     = (state == join_ctrl_pkg::st_oper);
  assign op_complete = (state == join_ctrl_pkg::st_end);
  assign op_error    = (state == join_ctrl_pkg::st_error);

  packet_arbiter #(
    .CHANNELS (CHANNELS)
  ) arbiter_inst (
    .clk         (clk),
    .int_rst     (int_rst),
    .restart     ((state == join_ctrl_pkg::st_end) || abort),
    .request     (mask_reg),
    .acknowledge (acknowledge),
    .grant       (grant),
    .grant_valid (grant_valid),
    .grant_index (grant_index)
  );

  stream_mux #(
    .CHANNELS   (CHANNELS),
    .DATA_WIDTH (`JOIN_DATA_WIDTH),
    .KEEP_WIDTH (`JOIN_KEEP_WIDTH)
  ) mux_inst (
    .s_tdata  (s_tdata),
    .s_tkeep  (s_tkeep),
    .s_tvalid (s_tvalid_gated),
    .s_tlast  (s_tlast),
    .s_tready (s_tready),
    .enable   (grant_valid),
    .select   (grant_index),
    .m_tdata  (m_tdata),
    .m_tkeep  (m_tkeep),
    .m_tvalid (m_tvalid),
    .m_tlast  (mux_tlast),
    .m_tready (m_tready)
  );

  status_exclusive_a: assert property (@(posedge clk) disable iff (int_rst)
    !(op_complete && op_error));

  // The arbiter grant must never reach a channel already dropped
  ready_in_mask_a: assert property (@(posedge clk) disable iff (int_rst)
    (s_tready & ~mask_reg) == '0);

endmodule

//--- test/packet_joiner_tb.sv
`timescale 1ns/10ps
`include "joiner_params.svh"

module packet_joiner_tb;

  localparam int CLK_PERIOD = 20;
  localparam int CH = `JOIN_CHANNELS;
  localparam int DW = `JOIN_DATA_WIDTH;
  localparam int KW = `JOIN_KEEP_WIDTH;
  localparam int MAX_BEATS = 16;
  localparam int GOLDEN_WORDS = 512;
  localparam int LAST_BIT = 20;
  localparam int WATCHDOG_MARGIN = 200;

  logic                 clk;
  logic                 int_rst;
  logic                 abort;
  logic                 op_start;
  logic [CH-1:0]        use_channels;
  logic [CH*DW-1:0]     s_tdata;
  logic [CH*KW-1:0]     s_tkeep;
  logic [CH-1:0]        s_tvalid;
  logic [CH-1:0]        s_tlast;
  logic [CH-1:0]        s_tready;
  logic [DW-1:0]        m_tdata;
  logic [KW-1:0]        m_tkeep;
  logic                 m_tvalid;
  logic                 m_tlast;
  logic                 m_tready;
  logic                 op_busy;
  logic                 op_complete;
  logic                 op_error;
  logic                 beat_xfer;

  // Source words hold {keep, data} and expected beats hold {last, keep, data}
  logic [23:0] golden [0:GOLDEN_WORDS-1];
  logic [23:0] src_word [CH][MAX_BEATS];
  logic [23:0] exp_word [CH*MAX_BEATS];
  int          src_len [CH];
  int          src_pos [CH];
  int          exp_len;
  int          seed = 32'h7077_7f11;
  int          watchdog_cycles = 0;

  packet_joiner packet_joiner_inst (
    .clk          (clk),
    .int_rst      (int_rst),
    .abort        (abort),
    .op_start     (op_start),
    .use_channels (use_channels),
    .s_tdata      (s_tdata),
    .s_tkeep      (s_tkeep),
    .s_tvalid     (s_tvalid),
    .s_tlast      (s_tlast),
    .s_tready     (s_tready),
    .m_tdata      (m_tdata),
    .m_tkeep      (m_tkeep),
    .m_tvalid     (m_tvalid),
    .m_tlast      (m_tlast),
    .m_tready     (m_tready),
    .op_busy      (op_busy),
    .op_complete  (op_complete),
    .op_error     (op_error),
    .beat_xfer    (beat_xfer)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic stop_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      stop_run();
    end
  endtask

  // Sum of all source beats in the golden file
  function automatic int golden_beat_total(input int n_tests);
    int ptr;
    int total;
    int len;
    ptr = 1;
    total = 0;
    for (int t = 0; t < n_tests; t++) begin
      ptr += 2;
      for (int ch = 0; ch < CH; ch++) begin
        len = int'(golden[ptr]);
        total += len;
        ptr += len + 1;
      end
      ptr += int'(golden[ptr]) + 1;
    end
    return total;
  endfunction

  task automatic load_test(inout int ptr, output logic [CH-1:0] mask, output int abort_after);
    int len;
    mask = golden[ptr][CH-1:0];
    abort_after = int'(golden[ptr+1]);
    ptr += 2;
    for (int ch = 0; ch < CH; ch++) begin
      len = int'(golden[ptr]);
      src_len[ch] = len;
      src_pos[ch] = 0;
      for (int i = 0; i < len; i++) begin
        src_word[ch][i] = golden[ptr+1+i];
      end
      ptr += len + 1;
    end
    exp_len = int'(golden[ptr]);
    for (int i = 0; i < exp_len; i++) begin
      exp_word[i] = golden[ptr+1+i];
    end
    ptr += exp_len + 1;
  endtask

  // Each source keeps its current beat on the bus until it is taken
  task automatic drive_sources();
    for (int ch = 0; ch < CH; ch++) begin
      if (src_pos[ch] < src_len[ch]) begin
        s_tvalid[ch] = 1'b1;
        s_tdata[ch*DW +: DW] = src_word[ch][src_pos[ch]][DW-1:0];
        s_tkeep[ch*KW +: KW] = src_word[ch][src_pos[ch]][DW+KW-1:DW];
        s_tlast[ch] = (src_pos[ch] == src_len[ch] - 1);
      end else begin
        s_tvalid[ch] = 1'b0;
        s_tdata[ch*DW +: DW] = '0;
        s_tkeep[ch*KW +: KW] = '0;
        s_tlast[ch] = 1'b0;
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      op_start = 1'b0;
      abort = 1'b0;
      m_tready = 1'b0;
    end
  endtask

  task automatic run_test(input logic [CH-1:0] mask, input int abort_after);
    int   cycle;
    int   accepted;
    int   xfer_count;
    int   post_abort;
    int   post_end;
    logic prev_hs;
    logic prev_final;
    logic ended;
    logic aborted;
    logic abort_now;
    logic hs;
    logic done;
    cycle = 0;
    accepted = 0;
    xfer_count = 0;
    post_abort = 0;
    post_end = 0;
    prev_hs = 1'b0;
    prev_final = 1'b0;
    ended = 1'b0;
    aborted = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      abort_now = (abort_after != 0) && (accepted == abort_after) && !aborted;
      op_start = (cycle == 0);
      use_channels = mask;
      abort = abort_now;
      // Consumer stalls during the abort cycle
      m_tready = abort_now ? 1'b0 : (($random(seed) % 4) != 0);
      drive_sources();
      #(CLK_PERIOD/4);
      if (prev_final) ended = 1'b1;
      if (beat_xfer) xfer_count++;
      check_value("beat_xfer", 32'(prev_hs), 32'(beat_xfer));
      check_value("op_complete", 32'(prev_final), 32'(op_complete));
      check_value("op_error", 32'((mask == '0) && (cycle == 1)), 32'(op_error));
      check_value("op_busy", 32'((mask != '0) && (cycle >= 1) && !ended && !aborted),
                  32'(op_busy));
      // Unselected channels are never offered ready
      check_value("s_tready", 0, 32'(s_tready & ~mask));
      if (aborted) begin
        check_value("m_tvalid", 0, 32'(m_tvalid));
        check_value("s_tready", 0, 32'(s_tready));
        post_abort++;
      end
      if (mask == '0) check_value("m_tvalid", 0, 32'(m_tvalid));
      hs = m_tvalid && m_tready;
      prev_final = 1'b0;
      if (hs) begin
        assert (accepted < exp_len) else begin
          $display("Error at %0t ns: output beat %0d arrived but only %0d were expected",
                   $time, accepted + 1, exp_len);
          stop_run();
        end
        check_value("m_tdata", 32'(exp_word[accepted][DW-1:0]), 32'(m_tdata));
        check_value("m_tkeep", 32'(exp_word[accepted][DW+KW-1:DW]), 32'(m_tkeep));
        check_value("m_tlast", 32'(exp_word[accepted][LAST_BIT]), 32'(m_tlast));
        prev_final = exp_word[accepted][LAST_BIT];
        accepted++;
      end
      for (int ch = 0; ch < CH; ch++) begin
        if (s_tvalid[ch] && s_tready[ch]) src_pos[ch]++;
      end
      prev_hs = hs;
      if (abort_now) aborted = 1'b1;
      // One more cycle after the pulse shows that op_complete drops again
      if (ended) post_end++;
      cycle++;
      if (mask == '0) done = (cycle == 3);
      else if (aborted) done = (post_abort == 4);
      else done = (post_end == 2);
    end
    check_value("beat_xfer count", 32'(exp_len), 32'(xfer_count));
  endtask

  initial begin : watchdog
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
    stop_run();
  end

  initial begin : main
    int            n_tests;
    int            ptr;
    int            abort_after;
    logic [CH-1:0] mask;
    int_rst = 1'b1;
    abort = 1'b0;
    op_start = 1'b0;
    use_channels = '0;
    s_tdata = '0;
    s_tkeep = '0;
    s_tvalid = '0;
    s_tlast = '0;
    m_tready = 1'b0;
    $readmemh("test/packet_joiner_golden.txt", golden);
    n_tests = int'(golden[0]);
    assert (n_tests > 0) else begin
      $display("Error: the golden file holds no tests");
      stop_run();
    end
    watchdog_cycles = golden_beat_total(n_tests) * 4 + WATCHDOG_MARGIN;
    repeat (3) @(posedge clk);
    #(CLK_PERIOD/4);
    check_value("op_busy", 0, 32'(op_busy));
    check_value("op_complete", 0, 32'(op_complete));
    check_value("op_error", 0, 32'(op_error));
    check_value("beat_xfer", 0, 32'(beat_xfer));
    check_value("m_tvalid", 0, 32'(m_tvalid));
    check_value("s_tready", 0, 32'(s_tready));
    @(negedge clk);
    int_rst = 1'b0;
    ptr = 1;
    for (int t = 0; t < n_tests; t++) begin
      load_test(ptr, mask, abort_after);
      idle_cycles(2);
      run_test(mask, abort_after);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- test/packet_joiner_golden.txt
// Test count, then per test: mask and abort-after-beat count (0 = no abort),
// three channel lines (length, then {keep,data} words), expected line (count, {last,keep,data})
7
// All channels joined in order
7 0
2 31000 11001
3 31100 31101 21102
1 31200
6 031000 011001 031100 031101 021102 131200
// Channels 0 and 2 only
5 0
1 12000
2 32100 32101
3 32200 32201 12202
4 012000 032200 032201 112202
// Channel 1 only
2 0
1 33000
3 33100 33101 23102
1 33200
3 033100 033101 123102
// Empty mask gives an error pulse
0 0
1 34000
1 34100
1 34200
0
// Normal start after the error
7 0
1 15000
1 35100
2 35200 25201
4 015000 035100 035200 125201
// Abort after three output beats
7 3
2 36000 36001
2 36100 36101
2 36200 36201
3 036000 036001 036100
// Recovery after the abort
6 0
2 37000 37001
2 37100 27101
1 17200
3 037100 027101 117200

//--- packet_joiner.f
+incdir+source
source/join_ctrl_pkg.sv
source/arb_pkg.sv
source/packet_arbiter.sv
source/stream_mux.sv
source/packet_joiner.sv
test/packet_joiner_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the packet joiner testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module packet_joiner_tb \
  -f packet_joiner.f || { echo "run_sim: build failed"; exit 1; }
sim_out="$(./obj_dir/Vpacket_joiner_tb 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "STATUS: PASS" \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }
